// ==== Bender.yml ====
package:
  name: rob_backend

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/rob_pkg.sv
      - hdl/alu_lane.sv
      - hdl/mul_lane.sv
      - hdl/reorder_buffer.sv
      - hdl/rob_backend_top.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - testbench/tb_clock_gen.sv
      - testbench/rob_backend_tb.sv

// ==== files.f ====
+incdir+hdl
hdl/rob_pkg.sv
hdl/alu_lane.sv
hdl/mul_lane.sv
hdl/reorder_buffer.sv
hdl/rob_backend_top.sv
testbench/tb_clock_gen.sv
testbench/rob_backend_tb.sv

// ==== hdl/alu_lane.sv ====
// Integer execution lane.
// Computes add, sub, and, or and signed set-less-than in a single
// registered stage and hands the result back with the entry tag.

`timescale 1ns/1ns
`default_nettype none

`include "rob_params.svh"

module alu_lane (
    input  wire logic                clk,
    input  wire logic                arst_n,
    input  wire logic                req_valid,
    input  wire rob_pkg::lane_req_t  req,
    output logic                     res_valid,
    output rob_pkg::result_t         res
);

    import rob_pkg::*;

    logic [`DATA_WIDTH-1:0] alu_value;

    // --------------------------------------------------
    // Combinational ALU
    // --------------------------------------------------

    // The reorder buffer never steers OP_MUL here, so it falls to the default.
    always_comb begin
        alu_value = '0;
        case (req.op)
            OP_ADD: alu_value = req.a + req.b;
            OP_SUB: alu_value = req.a - req.b;
            OP_AND: alu_value = req.a & req.b;
            OP_OR:  alu_value = req.a | req.b;
            // Signed compare, the result is 1 or 0.
            OP_SLT: alu_value[0] = ($signed(req.a) < $signed(req.b));
            default: alu_value = '0;
        endcase
    end

    // --------------------------------------------------
    // Result register
    // --------------------------------------------------

    // The valid bit is control state and is cleared by reset.
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            res_valid <= 1'b0;
        end else begin
            res_valid <= req_valid;
        end
    end

    // The payload only loads when a request is present.
    always_ff @(posedge clk) begin
        if (req_valid) begin
            res <= '{tag: req.tag, value: alu_value};
        end
    end

endmodule

`default_nettype wire

// ==== hdl/mul_lane.sv ====
// Pipelined multiply lane.
// Forms the low word of the product in the first stage, then moves it
// with its tag and a valid bit down a shift pipeline. A new multiply can
// enter every cycle, so up to STAGES of them are in flight.

`timescale 1ns/1ns
`default_nettype none

`include "rob_params.svh"

module mul_lane #(
    parameter int STAGES = `MUL_STAGES
) (
    input  wire logic                clk,
    input  wire logic                arst_n,
    input  wire logic                req_valid,
    input  wire rob_pkg::lane_req_t  req,
    output logic                     res_valid,
    output rob_pkg::result_t         res
);

    import rob_pkg::*;

    // One valid bit and one result word per stage.
    logic [STAGES-1:0]       stage_valid;
    result_t                 stage_res [STAGES];
    logic [`DATA_WIDTH-1:0]  product;

    // --------------------------------------------------
    // First stage
    // --------------------------------------------------

    // Only the low word of the product is kept, which is 32-bit wrap.
    assign product = req.a * req.b;

    // --------------------------------------------------
    // Shift pipeline
    // --------------------------------------------------

    // Valid bits are cleared by reset so no stale result is written back.
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            stage_valid <= '0;
        end else begin
            stage_valid[0] <= req_valid;
            for (int i = 1; i < STAGES; i++) begin
                stage_valid[i] <= stage_valid[i-1];
            end
        end
    end

    // Payload follows its valid bit and needs no reset.
    always_ff @(posedge clk) begin
        stage_res[0] <= '{tag: req.tag, value: product};
        for (int i = 1; i < STAGES; i++) begin
            stage_res[i] <= stage_res[i-1];
        end
    end

    // The last stage is the write-back port, STAGES cycles after issue.
    assign res_valid = stage_valid[STAGES-1];
    assign res       = stage_res[STAGES-1];

endmodule

`default_nettype wire

// ==== hdl/reorder_buffer.sv ====
// Reorder buffer.
// Tags each issued instruction with the tail entry and steers it to the
// integer or the multiply lane. Lane results are written back out of
// order into their entries. The head retires strictly in order, gated by
// a downstream credit count, and each retirement returns one issue credit.

`timescale 1ns/1ns
`default_nettype none

`include "rob_params.svh"

module reorder_buffer (
    input  wire logic                clk,
    input  wire logic                arst_n,
    // Issue side.
    input  wire logic                issue_valid,
    input  wire rob_pkg::issue_t     issue,
    output logic                     issue_credit,
    // Dispatch to the lanes.
    output logic                     alu_req_valid,
    output rob_pkg::lane_req_t       alu_req,
    output logic                     mul_req_valid,
    output rob_pkg::lane_req_t       mul_req,
    // Write-back from the lanes.
    input  wire logic                alu_res_valid,
    input  wire rob_pkg::result_t    alu_res,
    input  wire logic                mul_res_valid,
    input  wire rob_pkg::result_t    mul_res,
    // Commit side.
    output logic                     commit_valid,
    output rob_pkg::commit_t         commit,
    input  wire logic                commit_credit
);

    import rob_pkg::*;

    // Wide enough to hold every downstream credit at once.
    localparam int CREDIT_WIDTH = $clog2(`COMMIT_CREDITS + 1);

    // Pointers wrap on their own because the tag covers every entry.
    logic [`ROB_TAG_WIDTH-1:0]   head_ptr;
    logic [`ROB_TAG_WIDTH-1:0]   tail_ptr;

    // Per-entry state. Only the done flags are control state.
    logic [`ROB_ENTRIES-1:0]     done_flags;
    logic [`REG_ADDR_WIDTH-1:0]  rd_mem [`ROB_ENTRIES];
    logic [`DATA_WIDTH-1:0]      value_mem [`ROB_ENTRIES];

    logic [CREDIT_WIDTH-1:0]     down_credits;
    logic                        do_commit;
    logic                        is_mul;
    lane_req_t                   dispatch_req;

    // --------------------------------------------------
    // Dispatch
    // --------------------------------------------------

    // The issued instruction takes the tail entry as its tag.
    // Both lanes see the same request word; only one valid is raised.
    assign dispatch_req = '{op: issue.op, tag: tail_ptr, a: issue.a, b: issue.b};
    assign is_mul       = (issue.op == OP_MUL);

    assign alu_req_valid = issue_valid && !is_mul;
    assign alu_req       = dispatch_req;
    assign mul_req_valid = issue_valid && is_mul;
    assign mul_req       = dispatch_req;

    // --------------------------------------------------
    // Allocation and retirement pointers
    // --------------------------------------------------

    // The issuer holds one credit per entry, so the tail never overruns
    // the head and no full check is needed here.
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            tail_ptr <= '0;
            head_ptr <= '0;
        end else begin
            if (issue_valid) begin
                tail_ptr <= tail_ptr + 1'b1;
            end
            if (do_commit) begin
                head_ptr <= head_ptr + 1'b1;
            end
        end
    end

    // The destination register is stored when the entry is allocated.
    always_ff @(posedge clk) begin
        if (issue_valid) begin
            rd_mem[tail_ptr] <= issue.rd;
        end
    end

    // --------------------------------------------------
    // Write-back
    // --------------------------------------------------

    // Both lanes may write in the same cycle; their tags always differ
    // because every tag in flight belongs to a distinct entry.
    always_ff @(posedge clk) begin
        if (alu_res_valid) begin
            value_mem[alu_res.tag] <= alu_res.value;
        end
        if (mul_res_valid) begin
            value_mem[mul_res.tag] <= mul_res.value;
        end
    end

    // An entry becomes done on the edge after its result appears and is
    // cleared again when it retires. The head is already done when it
    // retires, so a write-back never targets the entry being cleared.
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            done_flags <= '0;
        end else begin
            if (alu_res_valid) begin
                done_flags[alu_res.tag] <= 1'b1;
            end
            if (mul_res_valid) begin
                done_flags[mul_res.tag] <= 1'b1;
            end
            if (do_commit) begin
                done_flags[head_ptr] <= 1'b0;
            end
        end
    end

    // --------------------------------------------------
    // In-order commit
    // --------------------------------------------------

    // The head retires once its result is in and downstream has room.
    assign do_commit = done_flags[head_ptr] && (down_credits != '0);

    // Commit valid and the returned issue credit pulse together.
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            commit_valid <= 1'b0;
            issue_credit <= 1'b0;
        end else begin
            commit_valid <= do_commit;
            issue_credit <= do_commit;
        end
    end

    always_ff @(posedge clk) begin
        if (do_commit) begin
            commit <= '{rd: rd_mem[head_ptr], value: value_mem[head_ptr]};
        end
    end

    // Downstream credits. A commit spends one and a grant pulse returns
    // one; when both happen in the same cycle the count stays put.
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            down_credits <= CREDIT_WIDTH'(`COMMIT_CREDITS);
        end else begin
            case ({do_commit, commit_credit})
                2'b10:   down_credits <= down_credits - 1'b1;
                2'b01:   down_credits <= down_credits + 1'b1;
                default: down_credits <= down_credits;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== hdl/rob_backend_top.sv ====
// Reorder-buffer back end, top level.
// Connects the reorder buffer to the single-cycle integer lane and the
// pipelined multiply lane. Issue and commit both use credit flow control.

`timescale 1ns/1ns
`default_nettype none

`include "rob_params.svh"

module rob_backend_top (
    input  wire logic                clk,
    input  wire logic                arst_n,
    input  wire logic                issue_valid,
    input  wire rob_pkg::issue_t     issue,
    output logic                     issue_credit,
    output logic                     commit_valid,
    output rob_pkg::commit_t         commit,
    input  wire logic                commit_credit
);

    import rob_pkg::*;

    // Dispatch from the buffer to the lanes.
    logic       alu_req_valid;
    lane_req_t  alu_req;
    logic       mul_req_valid;
    lane_req_t  mul_req;

    // Write-back from the lanes to the buffer.
    logic       alu_res_valid;
    result_t    alu_res;
    logic       mul_res_valid;
    result_t    mul_res;

    // --------------------------------------------------
    // Reorder buffer
    // --------------------------------------------------

    reorder_buffer u_rob (
        .clk           (clk),
        .arst_n        (arst_n),
        .issue_valid   (issue_valid),
        .issue         (issue),
        .issue_credit  (issue_credit),
        .alu_req_valid (alu_req_valid),
        .alu_req       (alu_req),
        .mul_req_valid (mul_req_valid),
        .mul_req       (mul_req),
        .alu_res_valid (alu_res_valid),
        .alu_res       (alu_res),
        .mul_res_valid (mul_res_valid),
        .mul_res       (mul_res),
        .commit_valid  (commit_valid),
        .commit        (commit),
        .commit_credit (commit_credit)
    );

    // --------------------------------------------------
    // Execution lanes
    // --------------------------------------------------

    alu_lane u_alu (
        .clk       (clk),
        .arst_n    (arst_n),
        .req_valid (alu_req_valid),
        .req       (alu_req),
        .res_valid (alu_res_valid),
        .res       (alu_res)
    );

    // The multiply depth sets the minimum mul issue-to-commit latency.
    mul_lane #(.STAGES(`MUL_STAGES)) u_mul (
        .clk       (clk),
        .arst_n    (arst_n),
        .req_valid (mul_req_valid),
        .req       (mul_req),
        .res_valid (mul_res_valid),
        .res       (mul_res)
    );

endmodule

`default_nettype wire

// ==== hdl/rob_params.svh ====
// Reorder-buffer back end, shared sizes.
// Widths, depths and credit counts that the package, the lanes and
// the reorder buffer agree on.

`ifndef ROB_PARAMS_SVH
`define ROB_PARAMS_SVH

// --------------------------------------------------
// Reorder buffer
// --------------------------------------------------

// Number of entries, which is also the issue credit count after reset.
`define ROB_ENTRIES 8

// A tag addresses one entry, so it must cover ROB_ENTRIES exactly.
`define ROB_TAG_WIDTH 3

// --------------------------------------------------
// Datapath
// --------------------------------------------------

`define DATA_WIDTH 32
`define REG_ADDR_WIDTH 5

// Depth of the multiply pipeline in cycles.
`define MUL_STAGES 4

// Downstream slots granted to the commit port after reset.
`define COMMIT_CREDITS 4

`endif

// ==== hdl/rob_pkg.sv ====
// Reorder-buffer back end types.
// Operation encoding and the packed structs that move between the
// issuer, the reorder buffer, the two execution lanes and downstream.

`default_nettype none

`include "rob_params.svh"

package rob_pkg;

    // Operations carried by an issued instruction.
    // Only OP_MUL goes to the multiply lane, all others go to the integer lane.
    typedef enum logic [2:0] {
        OP_ADD = 3'd0,
        OP_SUB = 3'd1,
        OP_AND = 3'd2,
        OP_OR  = 3'd3,
        OP_SLT = 3'd4,
        OP_MUL = 3'd5
    } op_e;

    // Instruction as it arrives from the issuer, with its operands resolved.
    typedef struct packed {
        op_e                         op;
        logic [`REG_ADDR_WIDTH-1:0]  rd;
        logic [`DATA_WIDTH-1:0]      a;
        logic [`DATA_WIDTH-1:0]      b;
    } issue_t;

    // Instruction sent to a lane, tagged with its reorder-buffer entry.
    typedef struct packed {
        op_e                         op;
        logic [`ROB_TAG_WIDTH-1:0]   tag;
        logic [`DATA_WIDTH-1:0]      a;
        logic [`DATA_WIDTH-1:0]      b;
    } lane_req_t;

    // Result written back by a lane into the tagged entry.
    typedef struct packed {
        logic [`ROB_TAG_WIDTH-1:0]   tag;
        logic [`DATA_WIDTH-1:0]      value;
    } result_t;

    // Retired instruction handed to downstream.
    typedef struct packed {
        logic [`REG_ADDR_WIDTH-1:0]  rd;
        logic [`DATA_WIDTH-1:0]      value;
    } commit_t;

endpackage

`default_nettype wire

// ==== testbench/rob_backend_tb.sv ====
// Reorder-buffer back end testbench.
// Issues directed and random instruction streams under issue credit
// flow control, plays the downstream consumer that grants commit
// credits, and checks every commit against a reference model in order.

`timescale 1ns/1ns
`default_nettype none

`include "rob_params.svh"

module rob_backend_tb;

    import rob_pkg::*;

    // Instruction count of all tests together, used to size the watchdog.
    localparam int NUM_INSTR = 20 + 60 + `ROB_ENTRIES + `COMMIT_CREDITS + 2 * `ROB_ENTRIES;
    localparam int WATCHDOG_CYCLES = NUM_INSTR * (`MUL_STAGES + 20) + 200;

    logic     clk;
    logic     arst_n;
    logic     issue_valid;
    issue_t   issue;
    logic     issue_credit;
    logic     commit_valid;
    commit_t  commit;
    logic     commit_credit;

    // Issuer and downstream model state.
    int       seed = 32'h96df;
    int       issue_credits = `ROB_ENTRIES;
    int       pending_grants = 0;
    int       total_commits = 0;
    int       value_errors = 0;
    int       protocol_errors = 0;
    logic     withhold = 1'b0;
    logic     grant_next = 1'b0;
    commit_t  expected_q[$];

    tb_clock_gen #(.PERIOD_NS(20), .RESET_CYCLES(8)) clk_gen (
        .clk    (clk),
        .arst_n (arst_n)
    );

    rob_backend_top uut (
        .clk           (clk),
        .arst_n        (arst_n),
        .issue_valid   (issue_valid),
        .issue         (issue),
        .issue_credit  (issue_credit),
        .commit_valid  (commit_valid),
        .commit        (commit),
        .commit_credit (commit_credit)
    );

    // --------------------------------------------------
    // Reference model and compare tasks
    // --------------------------------------------------

    // Result of one instruction as downstream should see it.
    function automatic commit_t expected_commit(input issue_t instr);
        commit_t c;
        c.rd = instr.rd;
        case (instr.op)
            OP_ADD:  c.value = instr.a + instr.b;
            OP_SUB:  c.value = instr.a - instr.b;
            OP_AND:  c.value = instr.a & instr.b;
            OP_OR:   c.value = instr.a | instr.b;
            OP_SLT:  c.value = ($signed(instr.a) < $signed(instr.b)) ? 32'd1 : 32'd0;
            OP_MUL:  c.value = instr.a * instr.b;
            default: c.value = '0;
        endcase
        return c;
    endfunction

    task automatic check_commit(input commit_t got, input commit_t exp);
        if (got !== exp) begin
            $display("ERR %0t: commit rd=%0d value=%08h, expected rd=%0d value=%08h",
                     $time, got.rd, got.value, exp.rd, exp.value);
            value_errors++;
        end
    endtask

    task automatic check_credit_count(input int got, input int exp, input string what);
        if (got != exp) begin
            $display("ERR %0t: %s is %0d, expected %0d", $time, what, got, exp);
            value_errors++;
        end
    endtask

    task automatic check_bit(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            $display("ERR %0t: %s is %b, expected %b", $time, what, got, exp);
            value_errors++;
        end
    endtask

    // --------------------------------------------------
    // Issue side
    // --------------------------------------------------

    // Inputs change 2 ns after the rising edge.
    task automatic next_drive();
        @(posedge clk);
        #2;
    endtask

    task automatic random_instr(input logic alu_only, output issue_t instr);
        logic [31:0] bits;
        int          op_idx;
        bits = $random(seed);
        op_idx = alu_only ? (bits[15:0] % 5) : (bits[15:0] % 6);
        instr.op = op_e'(op_idx);
        bits = $random(seed);
        instr.rd = bits[`REG_ADDR_WIDTH-1:0];
        instr.a = $random(seed);
        instr.b = $random(seed);
    endtask

    // Spends one credit and records the expected commit in issue order.
    task automatic issue_one(input issue_t instr);
        while (issue_credits == 0) begin
            next_drive();
        end
        issue_valid = 1'b1;
        issue = instr;
        issue_credits--;
        expected_q.push_back(expected_commit(instr));
        next_drive();
        issue_valid = 1'b0;
    endtask

    // Waits until every instruction has committed and every grant is out.
    task automatic wait_drain();
        while (expected_q.size() != 0 || pending_grants != 0) begin
            next_drive();
        end
        repeat (3) next_drive();
        check_credit_count(issue_credits, `ROB_ENTRIES, "issue credits after drain");
    endtask

    // --------------------------------------------------
    // Commit monitor and downstream model
    // --------------------------------------------------

    // Outputs are sampled on the falling edge, where they are stable.
    always @(negedge clk) begin
        if (!arst_n) begin
            grant_next = 1'b0;
        end else begin
            check_bit(issue_credit, commit_valid, "issue_credit beside commit_valid");
            if (issue_credit) begin
                issue_credits++;
                if (issue_credits > `ROB_ENTRIES) begin
                    $display("More issue credits came back than entries exist at %0t", $time);
                    protocol_errors++;
                end
            end
            if (commit_valid) begin
                total_commits++;
                pending_grants++;
                if (expected_q.size() == 0) begin
                    $display("A commit appeared with no instruction outstanding at %0t", $time);
                    protocol_errors++;
                end else begin
                    check_commit(commit, expected_q.pop_front());
                end
            end
            // Downstream frees one slot per cycle unless it is holding back.
            grant_next = !withhold && (pending_grants > 0);
            if (grant_next) begin
                pending_grants--;
            end
        end
    end

    initial begin
        commit_credit = 1'b0;
        forever begin
            next_drive();
            commit_credit = grant_next;
        end
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Timeout after %0d cycles, the back end stopped making progress",
                 WATCHDOG_CYCLES);
        $display("SIMULATION FAILED");
        $finish;
    end

    // --------------------------------------------------
    // Test sequence
    // --------------------------------------------------

    initial begin
        issue_t instr;
        int     start_commits;
        int     burst;
        issue_valid = 1'b0;
        issue = '0;
        @(posedge arst_n);

        // Nothing is issued yet, so both pulses must stay quiet.
        repeat (4) begin
            @(negedge clk);
            check_bit(commit_valid, 1'b0, "commit_valid after reset");
            check_bit(issue_credit, 1'b0, "issue_credit after reset");
        end
        next_drive();

        // Integer ops only.
        repeat (20) begin
            random_instr(1'b1, instr);
            issue_one(instr);
        end
        wait_drain();

        // A multiply with younger integer ops that finish ahead of it.
        instr = '{op: OP_MUL, rd: 5'd1, a: 32'hffff_fff3, b: 32'd7};
        issue_one(instr);
        repeat (3) begin
            random_instr(1'b1, instr);
            issue_one(instr);
        end
        repeat (56) begin
            random_instr(1'b0, instr);
            issue_one(instr);
            // Leave an idle cycle after roughly one op in four.
            if (instr.a[1:0] == 2'b00) begin
                next_drive();
            end
        end
        wait_drain();

        // Back to back until the issuer runs dry with downstream held back.
        withhold = 1'b1;
        burst = 0;
        while (issue_credits > 0 && burst < 2 * `ROB_ENTRIES) begin
            random_instr(1'b0, instr);
            issue_one(instr);
            burst++;
        end
        repeat (12) next_drive();
        check_credit_count(expected_q.size(), `ROB_ENTRIES, "entries held while stalled");
        check_credit_count(issue_credits, 0, "issue credits while stalled");
        withhold = 1'b0;
        wait_drain();

        // Only the reset grant of downstream credits may be used up.
        withhold = 1'b1;
        start_commits = total_commits;
        repeat (`ROB_ENTRIES) begin
            random_instr(1'b0, instr);
            issue_one(instr);
        end
        repeat (20) next_drive();
        check_credit_count(total_commits - start_commits, `COMMIT_CREDITS,
                           "commits while credits withheld");
        withhold = 1'b0;
        repeat (`ROB_ENTRIES) begin
            random_instr(1'b0, instr);
            issue_one(instr);
        end
        wait_drain();

        $display("Done: %0d commits, %0d value errors, %0d protocol errors",
                 total_commits, value_errors, protocol_errors);
        if (value_errors == 0 && protocol_errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== testbench/tb_clock_gen.sv ====
// Testbench clock and reset source.
// Toggles a free-running clock and holds the active-low asynchronous
// reset for a fixed number of cycles before releasing it.

`timescale 1ns/1ns
`default_nettype none

module tb_clock_gen #(
    parameter int PERIOD_NS    = 20,
    parameter int RESET_CYCLES = 8
) (
    output logic clk,
    output logic arst_n
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

    // Reset is released just after a rising edge, away from the sampling point.
    initial begin
        arst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #2 arst_n = 1'b1;
    end

endmodule

`default_nettype wire
